/* include/stats_defs.svh */
/*
 * Width and depth macros for the stats subsystem.
 * Included by the package, the RTL and the testbench.
 */
`ifndef STATS_DEFS_SVH
`define STATS_DEFS_SVH

// narrow NoC flit and wide response beat.
`define NOC1_DATA_W      64
`define NOC_DATA_W       256

`define MSG_LENGTH_WIDTH 8
`define COORD_W          4

// tracker table.
`define TRACKER_ADDR_W   8
`define TRACKER_DEPTH    256

`endif

/* hw/stats_pkg.sv */
/*
 * Enums and flit layouts shared by the stats requester, the tracker and the testbench.
 */
`include "stats_defs.svh"

package stats_pkg;

    typedef enum logic {
        META_REQ = 1'b0,
        READ_REQ = 1'b1
    } req_type_e;

    typedef enum logic [7:0] {
        TRACKER_MSG  = 8'd32,
        TRACKER_RESP = 8'd33
    } msg_type_e;

    localparam int ROUTING_PAD_W = `NOC1_DATA_W - 3 * `COORD_W - `MSG_LENGTH_WIDTH - 8;
    localparam int MISC_PAD_W    = `NOC1_DATA_W - 3 * `COORD_W - `MSG_LENGTH_WIDTH;

    typedef struct packed {
        logic [`COORD_W-1:0]          dst_x_coord;
        logic [`COORD_W-1:0]          dst_y_coord;
        logic [`COORD_W-1:0]          dst_fbits;
        logic [`MSG_LENGTH_WIDTH-1:0] msg_len;
        msg_type_e                    msg_type;
        logic [ROUTING_PAD_W-1:0]     padding;
    } routing_hdr_flit;

    typedef struct packed {
        logic [`COORD_W-1:0]          src_x_coord;
        logic [`COORD_W-1:0]          src_y_coord;
        logic [`COORD_W-1:0]          src_fbits;
        logic [`MSG_LENGTH_WIDTH-1:0] metadata_flits;
        logic [MISC_PAD_W-1:0]        padding;
    } misc_hdr_flit;

    // request payload, sent in the top bits of a flit.
    typedef struct packed {
        req_type_e                  req_type;
        logic [`TRACKER_ADDR_W-1:0] start_addr;
        logic [`TRACKER_ADDR_W-1:0] end_addr;
    } tracker_flit;

    localparam int TRACKER_FLIT_W = $bits(tracker_flit);

    // metadata answer, sent in the top bits of a flit.
    typedef struct packed {
        req_type_e                req_type;
        logic [31:0]              record_count;
        logic [`TRACKER_ADDR_W:0] entry_count;
    } tracker_meta_flit;

    localparam int TRACKER_META_W = $bits(tracker_meta_flit);

    typedef struct packed {
        logic [`COORD_W-1:0]        dst_x;
        logic [`COORD_W-1:0]        dst_y;
        logic [`COORD_W-1:0]        dst_fbits;
        req_type_e                  req_type;
        logic [`TRACKER_ADDR_W-1:0] start_addr;
        logic [`TRACKER_ADDR_W-1:0] end_addr;
    } requester_input;

endpackage

/* hw/stream_if.sv */
/*
 * Valid/ready stream with a last marker.
 * The producer takes the source modport and the consumer the sink modport.
 */
`timescale 1ns/100ps

interface stream_if #(
    parameter int DATA_W = 64
);
    logic              val;
    logic [DATA_W-1:0] data;
    logic              last;
    logic              rdy;

    modport source (output val, output data, output last, input rdy);
    modport sink (input val, input data, input last, output rdy);
endinterface

/* hw/narrow_to_wide.sv */
/*
 * Packs narrow stream flits into wide beats, most significant lane first.
 * A last flit closes the beat early with the unfilled lanes zero.
 */
`timescale 1ns/100ps

module narrow_to_wide #(
    parameter int IN_DATA_W    = 64,
    parameter int OUT_DATA_ELS = 4
) (
    input  logic     clk,
    input  logic     rst,
    stream_if.sink   in,
    stream_if.source out
);
    localparam int OUT_DATA_W = IN_DATA_W * OUT_DATA_ELS;
    localparam int LANE_W     = $clog2(OUT_DATA_ELS);

    logic [LANE_W-1:0]     lane_cnt;
    logic [OUT_DATA_W-1:0] data_reg;
    logic [OUT_DATA_W-1:0] data_next;
    logic                  last_reg;
    logic                  val_reg;
    logic                  in_fire;
    logic                  beat_done;

    // a full beat blocks input until the sink takes it.
    assign in.rdy    = ~val_reg | out.rdy;
    assign in_fire   = in.val & in.rdy;
    assign beat_done = (lane_cnt == LANE_W'(OUT_DATA_ELS - 1)) | in.last;

    always_comb begin
        // the first lane of a beat clears the others.
        data_next = (lane_cnt == '0) ? '0 : data_reg;
        data_next[(OUT_DATA_ELS - 1 - lane_cnt) * IN_DATA_W +: IN_DATA_W] = in.data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lane_cnt <= '0;
            val_reg  <= 1'b0;
            last_reg <= 1'b0;
        end else begin
            if (val_reg && out.rdy) begin
                val_reg <= 1'b0;
            end
            if (in_fire) begin
                if (beat_done) begin
                    lane_cnt <= '0;
                    val_reg  <= 1'b1;
                    last_reg <= in.last;
                end else begin
                    lane_cnt <= lane_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            data_reg <= data_next;
        end
    end

    assign out.val  = val_reg;
    assign out.data = data_reg;
    assign out.last = last_reg;

endmodule

/* hw/stats_requester.sv */
/*
 * Takes one request from the local source, sends it to the tracker as three NoC flits
 * and returns the answer on the wide stream: the meta flit alone, or only the entries.
 */
`timescale 1ns/100ps
`include "stats_defs.svh"

module stats_requester #(
    parameter logic [`COORD_W-1:0] SRC_X = '0,
    parameter logic [`COORD_W-1:0] SRC_Y = '0
) (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      hdr_val,
    input  stats_pkg::requester_input req,
    output logic                      hdr_rdy,

    output logic                      resp_val,
    output logic [`NOC_DATA_W-1:0]    resp_data,
    output logic                      resp_last,
    input  logic                      resp_rdy,

    output logic                      noc_out_val,
    output logic [`NOC1_DATA_W-1:0]   noc_out_data,
    input  logic                      noc_out_rdy,

    input  logic                      noc_in_val,
    input  logic [`NOC1_DATA_W-1:0]   noc_in_data,
    output logic                      noc_in_rdy
);
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_REQ_HDR_1,
        ST_REQ_HDR_2,
        ST_REQ_PAYLOAD,
        ST_RESP_HDR_1,
        ST_RESP_HDR_2,
        ST_RESP_META,
        ST_DATA_PASS,
        ST_DRAIN
    } state_e;

    state_e                       state_reg;
    state_e                       state_next;

    stats_pkg::requester_input    req_reg;
    stats_pkg::routing_hdr_flit   req_hdr;
    stats_pkg::misc_hdr_flit      req_misc;
    stats_pkg::tracker_flit       req_payload;
    stats_pkg::routing_hdr_flit   resp_hdr;

    logic [`MSG_LENGTH_WIDTH-1:0] num_flits_reg;
    logic [`MSG_LENGTH_WIDTH-1:0] curr_flits_reg;
    logic                         store_num_flits;
    logic                         incr_curr_flits;
    logic                         is_meta;
    logic                         noc_in_fire;

    stream_if #(.DATA_W(`NOC1_DATA_W)) narrow_s ();
    stream_if #(.DATA_W(`NOC_DATA_W))  wide_s ();

    assign resp_hdr    = noc_in_data;
    assign is_meta     = (req_reg.req_type == stats_pkg::META_REQ);
    assign noc_in_fire = noc_in_val & noc_in_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= ST_IDLE;
        end else begin
            state_reg <= state_next;
        end
    end

    // curr_flits counts the flit on the link, the misc header being flit 1.
    // msg_len wraps for long reads, and the modulo count still lands on the last flit.
    always_ff @(posedge clk) begin
        if (state_reg == ST_IDLE && hdr_val) begin
            req_reg <= req;
        end
        if (store_num_flits) begin
            num_flits_reg  <= resp_hdr.msg_len;
            curr_flits_reg <= `MSG_LENGTH_WIDTH'(1);
        end else if (incr_curr_flits) begin
            curr_flits_reg <= curr_flits_reg + 1'b1;
        end
    end

    always_comb begin
        state_next      = state_reg;
        hdr_rdy         = 1'b0;
        noc_out_val     = 1'b0;
        store_num_flits = 1'b0;
        incr_curr_flits = 1'b0;
        case (state_reg)
            ST_IDLE: begin
                hdr_rdy = 1'b1;
                if (hdr_val) begin
                    state_next = ST_REQ_HDR_1;
                end
            end
            ST_REQ_HDR_1: begin
                noc_out_val = 1'b1;
                if (noc_out_rdy) begin
                    state_next = ST_REQ_HDR_2;
                end
            end
            ST_REQ_HDR_2: begin
                noc_out_val = 1'b1;
                if (noc_out_rdy) begin
                    state_next = ST_REQ_PAYLOAD;
                end
            end
            ST_REQ_PAYLOAD: begin
                noc_out_val = 1'b1;
                if (noc_out_rdy) begin
                    state_next = ST_RESP_HDR_1;
                end
            end
            ST_RESP_HDR_1: begin
                if (noc_in_fire) begin
                    store_num_flits = 1'b1;
                    state_next      = ST_RESP_HDR_2;
                end
            end
            ST_RESP_HDR_2: begin
                if (noc_in_fire) begin
                    incr_curr_flits = 1'b1;
                    state_next      = ST_RESP_META;
                end
            end
            ST_RESP_META: begin
                if (noc_in_fire) begin
                    incr_curr_flits = 1'b1;
                    state_next      = is_meta ? ST_IDLE : ST_DATA_PASS;
                end
            end
            ST_DATA_PASS: begin
                if (noc_in_fire) begin
                    incr_curr_flits = 1'b1;
                    if (narrow_s.last) begin
                        state_next = ST_DRAIN;
                    end
                end
            end
            ST_DRAIN: begin
                if (wide_s.val && wide_s.rdy && wide_s.last) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    assign narrow_s.data = noc_in_data;
    assign narrow_s.last = (curr_flits_reg == num_flits_reg);

    always_comb begin
        noc_in_rdy   = 1'b0;
        resp_val     = 1'b0;
        resp_last    = 1'b0;
        resp_data    = wide_s.data;
        narrow_s.val = 1'b0;
        wide_s.rdy   = 1'b0;
        case (state_reg)
            ST_RESP_HDR_1, ST_RESP_HDR_2: begin
                noc_in_rdy = 1'b1;
            end
            ST_RESP_META: begin
                // a read drops the meta flit.
                resp_data  = {noc_in_data, {(`NOC_DATA_W - `NOC1_DATA_W){1'b0}}};
                resp_val   = is_meta & noc_in_val;
                resp_last  = is_meta & noc_in_val;
                noc_in_rdy = resp_rdy | ~is_meta;
            end
            ST_DATA_PASS: begin
                narrow_s.val = noc_in_val;
                noc_in_rdy   = narrow_s.rdy;
                resp_val     = wide_s.val;
                resp_last    = wide_s.val & wide_s.last;
                wide_s.rdy   = resp_rdy;
            end
            ST_DRAIN: begin
                resp_val   = wide_s.val;
                resp_last  = wide_s.val & wide_s.last;
                wide_s.rdy = resp_rdy;
            end
            default: begin
                noc_in_rdy = 1'b0;
            end
        endcase
    end

    always_comb begin
        req_hdr             = '0;
        req_hdr.dst_x_coord = req_reg.dst_x;
        req_hdr.dst_y_coord = req_reg.dst_y;
        req_hdr.dst_fbits   = req_reg.dst_fbits;
        req_hdr.msg_len     = `MSG_LENGTH_WIDTH'(2);
        req_hdr.msg_type    = stats_pkg::TRACKER_MSG;

        req_misc                = '0;
        req_misc.src_x_coord    = SRC_X;
        req_misc.src_y_coord    = SRC_Y;
        req_misc.metadata_flits = `MSG_LENGTH_WIDTH'(1);

        req_payload.req_type   = req_reg.req_type;
        req_payload.start_addr = req_reg.start_addr;
        req_payload.end_addr   = req_reg.end_addr;
    end

    always_comb begin
        noc_out_data = '0;
        case (state_reg)
            ST_REQ_HDR_1: begin
                noc_out_data = req_hdr;
            end
            ST_REQ_HDR_2: begin
                noc_out_data = req_misc;
            end
            ST_REQ_PAYLOAD: begin
                noc_out_data[`NOC1_DATA_W-1 -: stats_pkg::TRACKER_FLIT_W] = req_payload;
            end
            default: begin
                noc_out_data = '0;
            end
        endcase
    end

    narrow_to_wide #(
        .IN_DATA_W    (`NOC1_DATA_W),
        .OUT_DATA_ELS (`NOC_DATA_W / `NOC1_DATA_W)
    ) u_ntw (
        .clk (clk),
        .rst (rst),
        .in  (narrow_s),
        .out (wide_s)
    );

endmodule

/* hw/stats_tracker.sv */
/*
 * Records strobed sample words into a table and answers metadata and read
 * requests arriving on the NoC with a header, a meta flit and the entries.
 */
`timescale 1ns/100ps
`include "stats_defs.svh"

module stats_tracker (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    record_val,
    input  logic [`NOC1_DATA_W-1:0] record_data,

    input  logic                    noc_in_val,
    input  logic [`NOC1_DATA_W-1:0] noc_in_data,
    output logic                    noc_in_rdy,

    output logic                    noc_out_val,
    output logic [`NOC1_DATA_W-1:0] noc_out_data,
    input  logic                    noc_out_rdy
);
    typedef enum logic [2:0] {
        ST_RX_HDR_1,
        ST_RX_HDR_2,
        ST_RX_PAYLOAD,
        ST_TX_HDR_1,
        ST_TX_HDR_2,
        ST_TX_META,
        ST_TX_DATA
    } state_e;

    logic [`NOC1_DATA_W-1:0]     stats_mem [`TRACKER_DEPTH];
    logic [`TRACKER_ADDR_W-1:0]  wr_ptr;
    logic [31:0]                 record_count;

    state_e                      state_reg;
    state_e                      state_next;

    stats_pkg::misc_hdr_flit     in_misc;
    stats_pkg::tracker_flit      in_req;
    stats_pkg::misc_hdr_flit     misc_reg;
    stats_pkg::tracker_flit      req_reg;
    logic [31:0]                 count_snap;

    stats_pkg::routing_hdr_flit  out_hdr;
    stats_pkg::misc_hdr_flit     out_misc;
    stats_pkg::tracker_meta_flit out_meta;
    logic [`TRACKER_ADDR_W:0]    entry_count;

    logic [`TRACKER_ADDR_W-1:0]  cur_addr;
    logic [`TRACKER_ADDR_W-1:0]  rd_addr;
    logic [`NOC1_DATA_W-1:0]     rd_data;

    assign in_misc = noc_in_data;
    assign in_req  = noc_in_data[`NOC1_DATA_W-1 -: stats_pkg::TRACKER_FLIT_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr       <= '0;
            record_count <= '0;
        end else if (record_val) begin
            wr_ptr       <= wr_ptr + 1'b1;
            record_count <= record_count + 1'b1;
        end
    end

    // rd_data always holds the entry at cur_addr.
    always_ff @(posedge clk) begin
        if (record_val) begin
            stats_mem[wr_ptr] <= record_data;
        end
        rd_data <= stats_mem[rd_addr];
    end

    always_comb begin
        rd_addr = cur_addr;
        if (state_reg == ST_RX_PAYLOAD && noc_in_val) begin
            rd_addr = in_req.start_addr;
        end else if (state_reg == ST_TX_DATA && noc_out_rdy) begin
            rd_addr = cur_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= ST_RX_HDR_1;
        end else begin
            state_reg <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        cur_addr <= rd_addr;
        if (state_reg == ST_RX_HDR_2 && noc_in_val) begin
            misc_reg <= in_misc;
        end
        if (state_reg == ST_RX_PAYLOAD && noc_in_val) begin
            req_reg    <= in_req;
            count_snap <= record_count;
        end
    end

    assign noc_in_rdy  = (state_reg == ST_RX_HDR_1) || (state_reg == ST_RX_HDR_2)
                      || (state_reg == ST_RX_PAYLOAD);
    assign noc_out_val = ~noc_in_rdy;

    always_comb begin
        state_next = state_reg;
        case (state_reg)
            ST_RX_HDR_1: begin
                if (noc_in_val) begin
                    state_next = ST_RX_HDR_2;
                end
            end
            ST_RX_HDR_2: begin
                if (noc_in_val) begin
                    state_next = ST_RX_PAYLOAD;
                end
            end
            ST_RX_PAYLOAD: begin
                if (noc_in_val) begin
                    state_next = ST_TX_HDR_1;
                end
            end
            ST_TX_HDR_1: begin
                if (noc_out_rdy) begin
                    state_next = ST_TX_HDR_2;
                end
            end
            ST_TX_HDR_2: begin
                if (noc_out_rdy) begin
                    state_next = ST_TX_META;
                end
            end
            ST_TX_META: begin
                if (noc_out_rdy) begin
                    state_next = (req_reg.req_type == stats_pkg::META_REQ)
                               ? ST_RX_HDR_1 : ST_TX_DATA;
                end
            end
            ST_TX_DATA: begin
                if (noc_out_rdy && cur_addr == req_reg.end_addr) begin
                    state_next = ST_RX_HDR_1;
                end
            end
            default: begin
                state_next = ST_RX_HDR_1;
            end
        endcase
    end

    assign entry_count = {1'b0, req_reg.end_addr} - {1'b0, req_reg.start_addr} + 1'b1;

    always_comb begin
        // answer goes back to the coordinates in the request's misc header.
        out_hdr             = '0;
        out_hdr.dst_x_coord = misc_reg.src_x_coord;
        out_hdr.dst_y_coord = misc_reg.src_y_coord;
        out_hdr.dst_fbits   = misc_reg.src_fbits;
        out_hdr.msg_type    = stats_pkg::TRACKER_RESP;
        out_hdr.msg_len     = (req_reg.req_type == stats_pkg::META_REQ)
                            ? `MSG_LENGTH_WIDTH'(2)
                            : `MSG_LENGTH_WIDTH'(entry_count + 2'd2);

        out_misc                = '0;
        out_misc.metadata_flits = `MSG_LENGTH_WIDTH'(1);

        out_meta.req_type     = req_reg.req_type;
        out_meta.record_count = count_snap;
        out_meta.entry_count  = entry_count;
    end

    always_comb begin
        noc_out_data = '0;
        case (state_reg)
            ST_TX_HDR_1: begin
                noc_out_data = out_hdr;
            end
            ST_TX_HDR_2: begin
                noc_out_data = out_misc;
            end
            ST_TX_META: begin
                noc_out_data[`NOC1_DATA_W-1 -: stats_pkg::TRACKER_META_W] = out_meta;
            end
            ST_TX_DATA: begin
                noc_out_data = rd_data;
            end
            default: begin
                noc_out_data = '0;
            end
        endcase
    end

endmodule

/* hw/stats_top.sv */
/*
 * Stats subsystem top: the requester and the tracker joined by a NoC link
 * in each direction, with the source and record ports brought out.
 */
`timescale 1ns/100ps
`include "stats_defs.svh"

module stats_top (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      hdr_val,
    input  stats_pkg::requester_input req,
    output logic                      hdr_rdy,

    output logic                      resp_val,
    output logic [`NOC_DATA_W-1:0]    resp_data,
    output logic                      resp_last,
    input  logic                      resp_rdy,

    input  logic                      record_val,
    input  logic [`NOC1_DATA_W-1:0]   record_data
);
    logic                    req_noc_val;
    logic [`NOC1_DATA_W-1:0] req_noc_data;
    logic                    req_noc_rdy;

    logic                    resp_noc_val;
    logic [`NOC1_DATA_W-1:0] resp_noc_data;
    logic                    resp_noc_rdy;

    stats_requester #(
        .SRC_X (4'd1),
        .SRC_Y (4'd0)
    ) u_requester (
        .clk          (clk),
        .rst          (rst),
        .hdr_val      (hdr_val),
        .req          (req),
        .hdr_rdy      (hdr_rdy),
        .resp_val     (resp_val),
        .resp_data    (resp_data),
        .resp_last    (resp_last),
        .resp_rdy     (resp_rdy),
        .noc_out_val  (req_noc_val),
        .noc_out_data (req_noc_data),
        .noc_out_rdy  (req_noc_rdy),
        .noc_in_val   (resp_noc_val),
        .noc_in_data  (resp_noc_data),
        .noc_in_rdy   (resp_noc_rdy)
    );

    stats_tracker u_tracker (
        .clk          (clk),
        .rst          (rst),
        .record_val   (record_val),
        .record_data  (record_data),
        .noc_in_val   (req_noc_val),
        .noc_in_data  (req_noc_data),
        .noc_in_rdy   (req_noc_rdy),
        .noc_out_val  (resp_noc_val),
        .noc_out_data (resp_noc_data),
        .noc_out_rdy  (resp_noc_rdy)
    );

endmodule

/* test/stats_tb.sv */
/*
 * Random-stimulus testbench for the stats subsystem.
 * Drives records and requests into stats_top and checks every response beat against a table model.
 */
`timescale 1ns/100ps
`include "stats_defs.svh"

module stats_tb;
    localparam int NUM_TRANS        = 40;
    localparam int CYCLES_PER_TRANS = 300;
    localparam int CLK_PERIOD       = 40;
    localparam int ADDR_W           = `TRACKER_ADDR_W;
    localparam int COUNT_W          = `TRACKER_ADDR_W + 1;
    localparam int LANES            = `NOC_DATA_W / `NOC1_DATA_W;
    localparam int META_W           = $bits(stats_pkg::tracker_meta_flit);

    logic                      clk;
    logic                      rst;
    logic                      hdr_val;
    stats_pkg::requester_input req;
    logic                      hdr_rdy;
    logic                      resp_val;
    logic [`NOC_DATA_W-1:0]    resp_data;
    logic                      resp_last;
    logic                      resp_rdy;
    logic                      record_val;
    logic [`NOC1_DATA_W-1:0]   record_data;

    integer                    seed = 32'h8415_6f55;

    // table model, written in the same order as the record strobe.
    logic [`NOC1_DATA_W-1:0]   model_mem [`TRACKER_DEPTH];
    int unsigned               model_count;
    int                        model_ptr;

    logic [`NOC_DATA_W-1:0]    exp_beats [$];

    stats_top UUT (
        .clk         (clk),
        .rst         (rst),
        .hdr_val     (hdr_val),
        .req         (req),
        .hdr_rdy     (hdr_rdy),
        .resp_val    (resp_val),
        .resp_data   (resp_data),
        .resp_last   (resp_last),
        .resp_rdy    (resp_rdy),
        .record_val  (record_val),
        .record_data (record_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(NUM_TRANS * CYCLES_PER_TRANS * CLK_PERIOD);
        $display("timeout: the transactions did not complete in the allowed time");
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    function automatic int pick(input int lo, input int hi);
        int r;
        r = $random(seed);
        r = r & 32'h7fff_ffff;
        return lo + (r % (hi - lo + 1));
    endfunction

    // ready is high about 70 percent of the time and low during reset.
    initial begin
        resp_rdy = 1'b0;
        forever begin
            @(posedge clk);
            if (rst) begin
                resp_rdy <= 1'b0;
            end else begin
                resp_rdy <= (pick(0, 99) < 70);
            end
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input logic [`NOC_DATA_W-1:0] got_data, input logic got_last,
                              input logic [`NOC_DATA_W-1:0] exp_data, input logic exp_last);
        if (got_data !== exp_data) begin
            abort_run($sformatf("error at %0t: resp_data got %h expected %h",
                                $time, got_data, exp_data));
        end
        if (got_last !== exp_last) begin
            abort_run($sformatf("error at %0t: resp_last got %b expected %b",
                                $time, got_last, exp_last));
        end
    endtask

    task automatic check_meta(input stats_pkg::tracker_meta_flit got,
                              input stats_pkg::tracker_meta_flit exp);
        if (got !== exp) begin
            abort_run($sformatf({"error at %0t: meta flit got type %0d count %0d entries %0d",
                                 " expected type %0d count %0d entries %0d"},
                                $time, got.req_type, got.record_count, got.entry_count,
                                exp.req_type, exp.record_count, exp.entry_count));
        end
    endtask

    // no response may appear while nothing is requested.
    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (resp_val !== 1'b0) begin
                abort_run("resp_val went high with no request outstanding");
            end
            if (hdr_rdy !== 1'b1) begin
                abort_run("hdr_rdy is low while the requester should be idle");
            end
        end
    endtask

    task automatic drive_records(input int n);
        logic [`NOC1_DATA_W-1:0] data;
        repeat (n) begin
            @(posedge clk);
            data = {$random(seed), $random(seed)};
            record_val  <= 1'b1;
            record_data <= data;
            model_mem[model_ptr] = data;
            model_ptr = (model_ptr + 1) % `TRACKER_DEPTH;
            model_count++;
        end
        @(posedge clk);
        record_val <= 1'b0;
    endtask

    function automatic stats_pkg::requester_input make_request(input stats_pkg::req_type_e t,
                                                               input int s, input int e);
        stats_pkg::requester_input r;
        r.dst_x      = 4'(pick(0, 15));
        r.dst_y      = 4'(pick(0, 15));
        r.dst_fbits  = 4'(pick(0, 15));
        r.req_type   = t;
        r.start_addr = ADDR_W'(s);
        r.end_addr   = ADDR_W'(e);
        return r;
    endfunction

    task automatic issue_request(input stats_pkg::requester_input r);
        @(posedge clk);
        hdr_val <= 1'b1;
        req     <= r;
        @(negedge clk);
        if (hdr_rdy !== 1'b1) begin
            abort_run("hdr_rdy is low when a request is offered in idle");
        end
        @(posedge clk);
        hdr_val <= 1'b0;
    endtask

    // checks each beat up to last against exp_beats and a stalled beat against its held copy.
    task automatic collect_response(input logic meta_resp,
                                    input stats_pkg::tracker_meta_flit exp_meta);
        int                          idx;
        logic                        done;
        logic                        stalled;
        logic [`NOC_DATA_W-1:0]      held_data;
        logic                        held_last;
        stats_pkg::tracker_meta_flit got_meta;
        idx     = 0;
        done    = 1'b0;
        stalled = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (stalled) begin
                if (resp_val !== 1'b1) begin
                    abort_run("resp_val dropped while resp_rdy was low");
                end
                check_data(resp_data, resp_last, held_data, held_last);
            end
            if (resp_val === 1'b1) begin
                if (resp_rdy) begin
                    if (idx >= exp_beats.size()) begin
                        abort_run("response has more beats than expected");
                    end
                    if (meta_resp) begin
                        got_meta = resp_data[`NOC_DATA_W-1 -: META_W];
                        check_meta(got_meta, exp_meta);
                    end
                    check_data(resp_data, resp_last, exp_beats[idx], idx == exp_beats.size() - 1);
                    idx++;
                    stalled = 1'b0;
                    done    = resp_last;
                end else begin
                    stalled   = 1'b1;
                    held_data = resp_data;
                    held_last = resp_last;
                end
            end
        end
    endtask

    task automatic run_meta(input int s, input int e);
        stats_pkg::tracker_meta_flit exp_meta;
        logic [`NOC_DATA_W-1:0]      beat;
        exp_meta.req_type     = stats_pkg::META_REQ;
        exp_meta.record_count = model_count;
        exp_meta.entry_count  = COUNT_W'(e - s + 1);
        beat = '0;
        beat[`NOC_DATA_W-1 -: META_W] = exp_meta;
        exp_beats = {};
        exp_beats.push_back(beat);
        issue_request(make_request(stats_pkg::META_REQ, s, e));
        collect_response(1'b1, exp_meta);
    endtask

    task automatic run_read(input int s, input int e);
        logic [`NOC_DATA_W-1:0] beat;
        int                     lane;
        beat = '0;
        exp_beats = {};
        for (int i = 0; i <= e - s; i++) begin
            lane = i % LANES;
            if (lane == 0 && i > 0) begin
                exp_beats.push_back(beat);
                beat = '0;
            end
            // first entry of a beat sits in the top lane.
            beat[`NOC_DATA_W - 1 - lane * `NOC1_DATA_W -: `NOC1_DATA_W] = model_mem[s + i];
        end
        exp_beats.push_back(beat);
        issue_request(make_request(stats_pkg::READ_REQ, s, e));
        collect_response(1'b0, '0);
    endtask

    task automatic run_random();
        int s;
        int e;
        s = pick(0, `TRACKER_DEPTH - 1);
        e = s + pick(0, 47);
        if (e > `TRACKER_DEPTH - 1) begin
            e = `TRACKER_DEPTH - 1;
        end
        drive_records(pick(0, 12));
        check_idle(pick(1, 3));
        if (pick(0, 1) == 0) begin
            run_meta(s, e);
        end else begin
            run_read(s, e);
        end
    endtask

    initial begin
        rst         = 1'b1;
        hdr_val     = 1'b0;
        req         = '0;
        record_val  = 1'b0;
        record_data = '0;
        model_count = 0;
        model_ptr   = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        check_idle(6);

        drive_records(24);
        check_idle(2);
        // one, four and five entries give one, one and two beats.
        run_read(3, 3);
        run_read(0, 3);
        run_read(10, 14);
        run_meta(0, 23);

        // wrap the write pointer so the low entries are overwritten.
        drive_records(300);
        check_idle(2);
        run_meta(5, 200);
        run_read(0, 40);
        run_read(250, 255);
        run_meta(255, 255);

        repeat (NUM_TRANS - 8) begin
            run_random();
        end
        check_idle(4);
        $display("test passed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
hw/stats_pkg.sv
hw/stream_if.sv
hw/narrow_to_wide.sv
hw/stats_requester.sv
hw/stats_tracker.sv
hw/stats_top.sv
test/stats_tb.sv

/* run.sh */
#!/bin/bash
# Builds the stats testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module stats_tb -f tb.f -o stats_sim \
    && ./obj_dir/stats_sim > sim.log 2>&1
cat sim.log 2>/dev/null

grep -qx "test passed" sim.log 2>/dev/null \
    && echo "result: pass" \
    || { echo "result: fail"; exit 1; }
